/* source/ts_pkg.sv */
package ts_pkg;

	// ********************
	// Field widths
	// ********************

	// Packed stamp, year in the top bits
	// year 16 | month 8 | date 8 | hour 8 | minute 8 | second 8 | microsecond 24
	localparam int STAMP_W      = 80;

	localparam int YEAR_W       = 16;
	localparam int BYTE_FIELD_W = 8;
	localparam int US_W         = 24;

	// ********************
	// Rollover limits
	// ********************

	// Last value before each field wraps
	localparam logic [US_W-1:0]         US_MAX   = 24'd999_999;
	localparam logic [BYTE_FIELD_W-1:0] SEC_MAX  = 8'd59;
	localparam logic [BYTE_FIELD_W-1:0] MIN_MAX  = 8'd59;
	localparam logic [BYTE_FIELD_W-1:0] HOUR_MAX = 8'd23;

	// ********************
	// Reset values
	// ********************

	// Power-up stamp reads 1970-01-01 08:00:00.000000
	localparam logic [YEAR_W-1:0]       RST_YEAR  = 16'd1970;
	localparam logic [BYTE_FIELD_W-1:0] RST_MONTH = 8'd1;
	localparam logic [BYTE_FIELD_W-1:0] RST_DATE  = 8'd1;
	localparam logic [BYTE_FIELD_W-1:0] RST_HOUR  = 8'd8;

	// Minute, second and microsecond come up at zero

endpackage

/* source/us_tick_gen.sv */
`timescale 1ns/10ps

module us_tick_gen #(
	parameter int CLKS_PER_US = 50
) (
	input  logic i_clk_50m,
	input  logic i_rst_n,
	input  logic i_load,
	output logic o_us_tick
);

	localparam int CNT_W = (CLKS_PER_US > 1) ? $clog2(CLKS_PER_US) : 1;
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLKS_PER_US - 1);

	logic [CNT_W-1:0] r_cnt;

	// A load restarts the microsecond so a new time gets a full first step
	always_ff @(posedge i_clk_50m or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_cnt <= '0;
		end else if (i_load || r_cnt == CNT_LAST) begin
			r_cnt <= '0;
		end else begin
			r_cnt <= r_cnt + 1'b1;
		end
	end

	assign o_us_tick = (r_cnt == CNT_LAST);

endmodule

/* source/time_of_day.sv */
`timescale 1ns/10ps

module time_of_day import ts_pkg::*; (
	input  logic                    i_clk_50m,
	input  logic                    i_rst_n,
	input  logic                    i_load,
	input  logic                    i_us_tick,
	input  logic [US_W-1:0]         i_set_us,
	input  logic [BYTE_FIELD_W-1:0] i_set_second,
	input  logic [BYTE_FIELD_W-1:0] i_set_minute,
	input  logic [BYTE_FIELD_W-1:0] i_set_hour,
	output logic [US_W-1:0]         o_us,
	output logic [BYTE_FIELD_W-1:0] o_second,
	output logic [BYTE_FIELD_W-1:0] o_minute,
	output logic [BYTE_FIELD_W-1:0] o_hour,
	output logic                    o_day_carry
);

	logic [US_W-1:0]         r_us;
	logic [BYTE_FIELD_W-1:0] r_second;
	logic [BYTE_FIELD_W-1:0] r_minute;
	logic [BYTE_FIELD_W-1:0] r_hour;

	logic w_us_wrap;
	logic w_sec_wrap;
	logic w_min_wrap;

	// ********************
	// Carry chain
	// ********************

	assign w_us_wrap   = i_us_tick && (r_us == US_MAX);
	assign w_sec_wrap  = w_us_wrap && (r_second == SEC_MAX);
	assign w_min_wrap  = w_sec_wrap && (r_minute == MIN_MAX);
	assign o_day_carry = w_min_wrap && (r_hour == HOUR_MAX);

	// ********************
	// Counters
	// ********************

	always_ff @(posedge i_clk_50m or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_us <= '0;
		end else if (i_load) begin
			r_us <= i_set_us;
		end else if (i_us_tick) begin
			r_us <= w_us_wrap ? '0 : r_us + 1'b1;
		end
	end

	always_ff @(posedge i_clk_50m or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_second <= '0;
		end else if (i_load) begin
			r_second <= i_set_second;
		end else if (w_us_wrap) begin
			r_second <= w_sec_wrap ? '0 : r_second + 1'b1;
		end
	end

	always_ff @(posedge i_clk_50m or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_minute <= '0;
		end else if (i_load) begin
			r_minute <= i_set_minute;
		end else if (w_sec_wrap) begin
			r_minute <= w_min_wrap ? '0 : r_minute + 1'b1;
		end
	end

	always_ff @(posedge i_clk_50m or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_hour <= RST_HOUR;
		end else if (i_load) begin
			r_hour <= i_set_hour;
		end else if (w_min_wrap) begin
			r_hour <= o_day_carry ? '0 : r_hour + 1'b1;
		end
	end

	assign o_us     = r_us;
	assign o_second = r_second;
	assign o_minute = r_minute;
	assign o_hour   = r_hour;

endmodule

/* source/calendar_date.sv */
`timescale 1ns/10ps

module calendar_date import ts_pkg::*; (
	input  logic                    i_clk_50m,
	input  logic                    i_rst_n,
	input  logic                    i_load,
	input  logic                    i_day_carry,
	input  logic [BYTE_FIELD_W-1:0] i_set_date,
	input  logic [BYTE_FIELD_W-1:0] i_set_month,
	input  logic [YEAR_W-1:0]       i_set_year,
	output logic [BYTE_FIELD_W-1:0] o_date,
	output logic [BYTE_FIELD_W-1:0] o_month,
	output logic [YEAR_W-1:0]       o_year
);

	localparam logic [BYTE_FIELD_W-1:0] DECEMBER = 8'd12;

	logic [BYTE_FIELD_W-1:0] r_date;
	logic [BYTE_FIELD_W-1:0] r_month;
	logic [YEAR_W-1:0]       r_year;

	logic                    w_leap;
	logic [BYTE_FIELD_W-1:0] w_month_len;
	logic                    w_month_wrap;
	logic                    w_year_wrap;

	// ********************
	// Month length
	// ********************

	// Divisible by four only, good for 1901 to 2099
	assign w_leap = (r_year[1:0] == 2'b00);

	always_comb begin
		case (r_month)
			8'd4, 8'd6, 8'd9, 8'd11: w_month_len = 8'd30;
			8'd2:                    w_month_len = w_leap ? 8'd29 : 8'd28;
			default:                 w_month_len = 8'd31;
		endcase
	end

	assign w_month_wrap = i_day_carry && (r_date == w_month_len);
	assign w_year_wrap  = w_month_wrap && (r_month == DECEMBER);

	// ********************
	// Counters
	// ********************

	always_ff @(posedge i_clk_50m or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_date <= RST_DATE;
		end else if (i_load) begin
			r_date <= i_set_date;
		end else if (i_day_carry) begin
			r_date <= w_month_wrap ? 8'd1 : r_date + 1'b1;
		end
	end

	always_ff @(posedge i_clk_50m or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_month <= RST_MONTH;
		end else if (i_load) begin
			r_month <= i_set_month;
		end else if (w_month_wrap) begin
			r_month <= w_year_wrap ? 8'd1 : r_month + 1'b1;
		end
	end

	always_ff @(posedge i_clk_50m or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_year <= RST_YEAR;
		end else if (i_load) begin
			r_year <= i_set_year;
		end else if (w_year_wrap) begin
			r_year <= r_year + 1'b1;
		end
	end

	assign o_date  = r_date;
	assign o_month = r_month;
	assign o_year  = r_year;

endmodule

/* source/stamp_latch.sv */
`timescale 1ns/10ps

module stamp_latch import ts_pkg::*; (
	input  logic               i_clk_50m,
	input  logic               i_rst_n,
	input  logic               i_send,
	input  logic [STAMP_W-1:0] i_stamp,
	output logic [STAMP_W-1:0] o_stamp,
	output logic               o_valid
);

	logic [STAMP_W-1:0] r_stamp;
	logic               r_valid;

	// Takes the stamp as it stood before the send edge, even during a load
	always_ff @(posedge i_clk_50m or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_stamp <= '0;
		end else if (i_send) begin
			r_stamp <= i_stamp;
		end
	end

	// One pulse per send strobe
	always_ff @(posedge i_clk_50m or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_valid <= 1'b0;
		end else begin
			r_valid <= i_send;
		end
	end

	assign o_stamp = r_stamp;
	assign o_valid = r_valid;

endmodule

/* source/time_stamp.sv */
`timescale 1ns/10ps

module time_stamp import ts_pkg::*; #(
	parameter int CLKS_PER_US = 50
) (
	input  logic               i_clk_50m,
	input  logic               i_rst_n,
	input  logic               i_send_sig,
	input  logic               i_time_stamp_sig,
	input  logic [STAMP_W-1:0] i_time_stamp_set,
	output logic [STAMP_W-1:0] o_time_stamp_get,
	output logic [STAMP_W-1:0] o_stamp_latched,
	output logic               o_stamp_valid
);

	// Field offsets in the packed word
	localparam int SEC_LSB   = US_W;
	localparam int MIN_LSB   = SEC_LSB + BYTE_FIELD_W;
	localparam int HOUR_LSB  = MIN_LSB + BYTE_FIELD_W;
	localparam int DATE_LSB  = HOUR_LSB + BYTE_FIELD_W;
	localparam int MONTH_LSB = DATE_LSB + BYTE_FIELD_W;
	localparam int YEAR_LSB  = MONTH_LSB + BYTE_FIELD_W;

	logic                    w_us_tick;
	logic                    w_day_carry;
	logic [US_W-1:0]         w_us;
	logic [BYTE_FIELD_W-1:0] w_second;
	logic [BYTE_FIELD_W-1:0] w_minute;
	logic [BYTE_FIELD_W-1:0] w_hour;
	logic [BYTE_FIELD_W-1:0] w_date;
	logic [BYTE_FIELD_W-1:0] w_month;
	logic [YEAR_W-1:0]       w_year;
	logic [STAMP_W-1:0]      w_stamp;

	us_tick_gen #(
		.CLKS_PER_US (CLKS_PER_US)
	) u_us_tick_gen (
		.i_clk_50m (i_clk_50m),
		.i_rst_n   (i_rst_n),
		.i_load    (i_time_stamp_sig),
		.o_us_tick (w_us_tick)
	);

	time_of_day u_time_of_day (
		.i_clk_50m    (i_clk_50m),
		.i_rst_n      (i_rst_n),
		.i_load       (i_time_stamp_sig),
		.i_us_tick    (w_us_tick),
		.i_set_us     (i_time_stamp_set[US_W-1:0]),
		.i_set_second (i_time_stamp_set[SEC_LSB +: BYTE_FIELD_W]),
		.i_set_minute (i_time_stamp_set[MIN_LSB +: BYTE_FIELD_W]),
		.i_set_hour   (i_time_stamp_set[HOUR_LSB +: BYTE_FIELD_W]),
		.o_us         (w_us),
		.o_second     (w_second),
		.o_minute     (w_minute),
		.o_hour       (w_hour),
		.o_day_carry  (w_day_carry)
	);

	calendar_date u_calendar_date (
		.i_clk_50m   (i_clk_50m),
		.i_rst_n     (i_rst_n),
		.i_load      (i_time_stamp_sig),
		.i_day_carry (w_day_carry),
		.i_set_date  (i_time_stamp_set[DATE_LSB +: BYTE_FIELD_W]),
		.i_set_month (i_time_stamp_set[MONTH_LSB +: BYTE_FIELD_W]),
		.i_set_year  (i_time_stamp_set[YEAR_LSB +: YEAR_W]),
		.o_date      (w_date),
		.o_month     (w_month),
		.o_year      (w_year)
	);

	assign w_stamp = {w_year, w_month, w_date, w_hour, w_minute, w_second, w_us};

	stamp_latch u_stamp_latch (
		.i_clk_50m (i_clk_50m),
		.i_rst_n   (i_rst_n),
		.i_send    (i_send_sig),
		.i_stamp   (w_stamp),
		.o_stamp   (o_stamp_latched),
		.o_valid   (o_stamp_valid)
	);

	assign o_time_stamp_get = w_stamp;

endmodule

/* verification/time_stamp_checker.sv */
`timescale 1ns/10ps

module time_stamp_checker import ts_pkg::*; (
	input logic               i_clk_50m,
	input logic               i_rst_n,
	input logic               i_send_sig,
	input logic               i_time_stamp_sig,
	input logic [STAMP_W-1:0] i_time_stamp_set,
	input logic [STAMP_W-1:0] o_time_stamp_get,
	input logic               o_stamp_valid
);

	// Failed assertions so far
	int fail_count = 0;

	// ********************
	// Capture pulse
	// ********************

	assert property (@(posedge i_clk_50m) disable iff (!i_rst_n)
		i_send_sig |=> o_stamp_valid)
		else begin
			fail_count++;
			$error("valid did not follow send");
		end

	// No send, no pulse
	assert property (@(posedge i_clk_50m) disable iff (!i_rst_n)
		!i_send_sig |=> !o_stamp_valid)
		else begin
			fail_count++;
			$error("valid high without a send");
		end

	// ********************
	// Load and ranges
	// ********************

	assert property (@(posedge i_clk_50m) disable iff (!i_rst_n)
		i_time_stamp_sig |=> (o_time_stamp_get == $past(i_time_stamp_set)))
		else begin
			fail_count++;
			$error("live stamp differs from the load word");
		end

	assert property (@(posedge i_clk_50m) disable iff (!i_rst_n)
		o_time_stamp_get[US_W-1:0] <= US_MAX)
		else begin
			fail_count++;
			$error("microseconds out of range");
		end

	assert property (@(posedge i_clk_50m) disable iff (!i_rst_n)
		o_time_stamp_get[US_W +: BYTE_FIELD_W] <= SEC_MAX)
		else begin
			fail_count++;
			$error("seconds out of range");
		end

endmodule

bind time_stamp time_stamp_checker u_checker (.*);

/* verification/tb_time_stamp.sv */
`timescale 1ns/10ps

module tb_time_stamp;

	localparam int CLKS = 5;
	localparam int CYCLE_LIMIT = 60_000;

	logic        clk_50m = 1'b0;
	logic        rst_n;
	logic        send_sig;
	logic        load_sig;
	logic [79:0] load_word;
	logic [79:0] stamp_get;
	logic [79:0] stamp_latched;
	logic        stamp_valid;

	// Reference model state
	int          m_year, m_month, m_date, m_hour, m_min, m_sec, m_us, m_cnt;
	logic [79:0] m_latched;
	logic        m_valid;
	logic [15:0] lfsr = 16'd16;
	int          cycles = 0;

	time_stamp #(
		.CLKS_PER_US (CLKS)
	) uut (
		.i_clk_50m        (clk_50m),
		.i_rst_n          (rst_n),
		.i_send_sig       (send_sig),
		.i_time_stamp_sig (load_sig),
		.i_time_stamp_set (load_word),
		.o_time_stamp_get (stamp_get),
		.o_stamp_latched  (stamp_latched),
		.o_stamp_valid    (stamp_valid)
	);

	always #10 clk_50m = ~clk_50m;

	// ********************
	// Random numbers
	// ********************

	// Taps 16, 14, 13, 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	function automatic int rand_range(input int lo, input int hi);
		return lo + int'(take_bits(24) % (hi - lo + 1));
	endfunction

	// ********************
	// Calendar model
	// ********************

	function automatic int month_days(input int month, input int year);
		case (month)
			4, 6, 9, 11: return 30;
			2:           return (year % 4 == 0) ? 29 : 28;
			default:     return 31;
		endcase
	endfunction

	function automatic logic [79:0] model_stamp();
		return {16'(m_year), 8'(m_month), 8'(m_date), 8'(m_hour), 8'(m_min), 8'(m_sec),
			24'(m_us)};
	endfunction

	task automatic advance_us();
		m_us++;
		if (m_us > 999_999) begin
			m_us = 0;
			m_sec++;
		end
		if (m_sec > 59) begin
			m_sec = 0;
			m_min++;
		end
		if (m_min > 59) begin
			m_min = 0;
			m_hour++;
		end
		if (m_hour > 23) begin
			m_hour = 0;
			m_date++;
		end
		if (m_date > month_days(m_month, m_year)) begin
			m_date = 1;
			m_month++;
		end
		if (m_month > 12) begin
			m_month = 1;
			m_year++;
		end
	endtask

	// Capture sees the old stamp, then load wins over the tick
	always @(posedge clk_50m or negedge rst_n) begin
		if (!rst_n) begin
			{m_year, m_month, m_date, m_hour} = {32'd1970, 32'd1, 32'd1, 32'd8};
			{m_min, m_sec, m_us, m_cnt} = '0;
			m_latched = '0;
			m_valid = 1'b0;
		end else begin
			m_valid = send_sig;
			if (send_sig)
				m_latched = model_stamp();
			if (load_sig) begin
				m_year = int'(load_word[79:64]);
				m_month = int'(load_word[63:56]);
				m_date = int'(load_word[55:48]);
				m_hour = int'(load_word[47:40]);
				m_min = int'(load_word[39:32]);
				m_sec = int'(load_word[31:24]);
				m_us = int'(load_word[23:0]);
				m_cnt = 0;
			end else if (m_cnt == CLKS - 1) begin
				m_cnt = 0;
				advance_us();
			end else begin
				m_cnt++;
			end
		end
	end

	// ********************
	// Checks
	// ********************

	task automatic stop_run(input string why);
		$display("Result: FAILED");
		$fatal(1, "%s", why);
	endtask

	function automatic string fmt_stamp(input logic [79:0] s);
		return $sformatf("%0d-%0d-%0d %0d:%0d:%0d.%0d", s[79:64], s[63:56], s[55:48],
			s[47:40], s[39:32], s[31:24], s[23:0]);
	endfunction

	task automatic check_stamp(input string name, input logic [79:0] exp,
		input logic [79:0] act);
		assert (act == exp) else begin
			$display("Error: %0t ns %s expected %s got %s", $time, name, fmt_stamp(exp),
				fmt_stamp(act));
			stop_run("a stamp output differs from the model");
		end
	endtask

	always @(negedge clk_50m) begin
		if (rst_n) begin
			check_stamp("live stamp", model_stamp(), stamp_get);
			check_stamp("latched stamp", m_latched, stamp_latched);
			assert (stamp_valid == m_valid) else begin
				$display("Error: %0t ns valid expected %0b got %0b", $time, m_valid, stamp_valid);
				stop_run("the valid pulse differs from the model");
			end
			assert (uut.u_checker.fail_count == 0) else
				stop_run("a bound assertion on the DUT failed");
		end
	end

	always @(posedge clk_50m) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT)
			stop_run("the simulation timed out before all tests finished");
	end

	// ********************
	// Stimulus
	// ********************

	task automatic load_time(input int y, mo, d, h, mi, s, us, run, send_bits);
		@(negedge clk_50m);
		load_word = {16'(y), 8'(mo), 8'(d), 8'(h), 8'(mi), 8'(s), 24'(us)};
		load_sig = 1'b1;
		send_sig = (take_bits(send_bits) == 0);
		@(negedge clk_50m);
		load_sig = 1'b0;
		send_sig = 1'b0;
		repeat (run) begin
			@(negedge clk_50m);
			send_sig = (take_bits(send_bits) == 0);
		end
	endtask

	task automatic random_load(input int run, input int send_bits);
		int y;
		int mo;
		y = rand_range(1901, 2099);
		mo = rand_range(1, 12);
		load_time(y, mo, rand_range(1, month_days(mo, y)), rand_range(0, 23),
			rand_range(0, 59), rand_range(0, 59), rand_range(0, 999_999), run, send_bits);
	endtask

	initial begin
		int y;
		int mo;
		rst_n = 1'b0;
		send_sig = 1'b0;
		load_sig = 1'b0;
		load_word = '0;
		repeat (8) @(negedge clk_50m);
		rst_n = 1'b1;
		@(negedge clk_50m);
		assert (stamp_get == {16'd1970, 8'd1, 8'd1, 8'd8, 8'd0, 8'd0, 24'd0}
			&& !stamp_valid && stamp_latched == '0) else begin
			$display("Error: %0t ns stamp after reset reads %s", $time, fmt_stamp(stamp_get));
			stop_run("the outputs after reset are wrong");
		end
		repeat (100) @(negedge clk_50m);

		repeat (40) random_load(rand_range(5, 200), 3);

		// Just before second, minute, hour and day rollovers
		for (int i = 0; i < 40; i++) begin
			y = rand_range(1901, 2099);
			mo = rand_range(1, 12);
			load_time(y, mo,
				(i % 4 == 3) ? month_days(mo, y) : rand_range(1, month_days(mo, y) - 1),
				(i % 4 >= 2) ? 23 : rand_range(0, 22), (i % 4 >= 1) ? 59 : rand_range(0, 58),
				59, rand_range(999_995, 999_999), rand_range(30, 60), 3);
		end

		// Last day of the month at midnight
		for (int i = 0; i < 40; i++) begin
			y = rand_range(1901, 2099);
			mo = rand_range(1, 12);
			if (i % 4 == 0) begin
				y = 1904 + 4 * rand_range(0, 48);
				mo = 2;
			end else if (i % 4 == 1) begin
				y = 1904 + 4 * rand_range(0, 48) - rand_range(1, 3);
				mo = 2;
			end else if (i % 4 == 2) begin
				mo = 12;
			end
			load_time(y, mo, month_days(mo, y), 23, 59, 59, 999_999, rand_range(10, 40), 3);
		end

		// Dense sends, back to back and on load edges
		repeat (40) random_load(rand_range(5, 50), 1);

		repeat (3) @(posedge clk_50m);
		if (uut.u_checker.fail_count == 0) begin
			$display("Result: PASSED");
			$finish;
		end else begin
			stop_run("a bound assertion on the DUT failed");
		end
	end

endmodule

/* verilog.f */
source/ts_pkg.sv
source/us_tick_gen.sv
source/time_of_day.sv
source/calendar_date.sv
source/stamp_latch.sv
source/time_stamp.sv
verification/time_stamp_checker.sv
verification/tb_time_stamp.sv

/* Makefile */
SIM := obj_dir/Vtb_time_stamp
SRCS := $(shell cat verilog.f)

.PHONY: all run clean

all: run

$(SIM): verilog.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_time_stamp -f verilog.f

run: $(SIM)
	$(SIM) > sim.log 2>&1; cat sim.log
	grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
